/* verif/debug_csr_vectors.txt */
# name halt ebreak step core_pc core_prv resume_req wr_strobe wr_addr wr_data rd_addr
# expected: rd_data rd_valid halted wr_err resume resume_pc resume_prv
reset 0 0 0 00000000 3 0 0 000 00000000 7b0 40000003 1 0 0 0 00000000 3
reset 0 0 0 00000000 3 0 1 7b2 12345678 7b1 00000000 1 0 0 0 00000000 3
wr_run 0 0 0 00000000 3 0 0 000 00000000 7b2 00000000 1 0 0 0 00000000 3
wr_run_ebrk_off 0 1 0 00000100 3 0 0 000 00000000 7b3 00000000 1 0 1 0 00000000 3
haltreq 1 0 0 00001000 0 0 0 000 00000000 7b2 00000000 1 0 0 0 00000000 3
haltreq 0 0 0 00000000 0 0 0 000 00000000 7b0 40000003 1 1 0 0 00000000 3
warl 0 0 0 00000000 0 0 1 7b0 ffffffff 7b0 400000c0 1 1 0 0 00001000 0
warl 0 0 0 00000000 0 0 0 000 00000000 7b1 00001000 1 1 0 0 00001000 0
warl_prv2 0 0 0 00000000 0 0 1 7b0 00009006 7b0 4000b0c7 1 1 0 0 00001000 3
warl_prv2 0 0 0 00000000 0 0 1 7b2 a5a5a5a5 7b0 4000b0c7 1 1 0 0 00001000 3
scratch 0 0 0 00000000 0 0 1 7b3 5a5a5a5a 7b0 400090c7 1 1 0 0 00001000 3
scratch 0 0 0 00000000 0 0 1 7b1 80000040 7b2 a5a5a5a5 1 1 0 0 00001000 3
scratch 0 0 0 00000000 0 0 1 7b4 deadbeef 7b3 5a5a5a5a 1 1 0 0 00001000 3
dpc_wr 0 0 0 00000000 0 0 0 000 00000000 7b1 80000040 1 1 0 0 80000040 3
bad_addr 0 0 0 00000000 0 0 0 000 00000000 7b4 00000000 0 1 1 0 80000040 3
resume 0 0 0 00000000 0 1 0 000 00000000 7b1 80000040 1 1 0 0 80000040 3
resume 0 0 0 00000000 0 0 0 000 00000000 7b0 400090c7 1 0 0 1 80000040 3
ebrk_pri 1 1 1 00002000 3 0 1 7b2 11111111 7b2 a5a5a5a5 1 0 0 0 80000040 3
deferred 0 0 0 00000000 0 0 1 7b2 22222222 7b2 a5a5a5a5 1 1 0 0 80000040 3
deferred 0 0 0 00000000 0 0 0 000 00000000 7b0 40009047 1 1 0 0 00002000 3
deferred 0 0 0 00000000 0 0 0 000 00000000 7b2 11111111 1 1 0 0 00002000 3
deferred 0 0 0 00000000 0 1 0 000 00000000 7b2 22222222 1 1 0 0 00002000 3
halt_pri 1 1 1 00003000 1 0 0 000 00000000 7b0 40009047 1 0 0 1 00002000 3
halt_pri 0 0 0 00000000 0 0 0 000 00000000 7b0 40009047 1 1 0 0 00002000 3
halt_pri 0 0 0 00000000 0 1 0 000 00000000 7b0 400090c5 1 1 0 0 00003000 1
step 0 0 1 00004000 0 0 0 000 00000000 7b1 00003000 1 0 0 1 00003000 1
step 0 0 0 00000000 0 0 0 000 00000000 7b1 00003000 1 1 0 0 00003000 1
halted_ignore 1 1 0 00005000 3 0 0 000 00000000 7b0 40009104 1 1 0 0 00004000 0
halted_ignore 0 0 0 00000000 0 0 0 000 00000000 7b1 00004000 1 1 0 0 00004000 0

/* debug_csr_unit.f */
rtl/debug_csr_pkg.sv
rtl/debug_entry_ctrl.sv
rtl/csr_req_queue.sv
rtl/debug_csr_file.sv
rtl/debug_csr_unit.sv
verif/debug_csr_checker.sv
verif/debug_csr_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the debug CSR testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
SIM=obj_dir/debug_csr_sim

verilator --binary --timing -f debug_csr_unit.f \
    --top-module debug_csr_unit_tb -Mdir obj_dir -o debug_csr_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./$SIM > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Finished with errors" "$LOG"; then
    exit 1
fi
exit 0

/* verif/debug_csr_unit_tb.sv */
module debug_csr_unit_tb;
    import debug_csr_pkg::*;

    localparam int QUEUE_DEPTH = 4;

    // One line of the vector file
    typedef struct packed {
        logic [127:0] name;
        logic         halt_req;
        logic         ebreak;
        logic         step_done;
        word_t        core_pc;
        priv_t        core_prv;
        logic         resume_req;
        logic         wr_strobe;
        csr_req_t     wr_req;
        csr_addr_t    rd_addr;
        word_t        exp_rd_data;
        logic         exp_rd_valid;
        logic         exp_halted;
        logic         exp_wr_err;
        logic         exp_resume;
        word_t        exp_resume_pc;
        priv_t        exp_resume_prv;
    } vector_t;

    logic    CLK;
    logic    nRST;
    vector_t cur;
    vector_t vecs [$];
    logic    check_en;
    logic    loaded;
    int      vec_idx;
    int      vec_count;
    int      file_errors;
    int      check_errors;
    int      total_errors;
    int      queue_level;
    logic    exp_queue_full;
    logic    entry_cycle;

    logic    halted;
    logic    resume;
    word_t   resume_pc;
    priv_t   resume_prv;
    logic    queue_full;
    logic    wr_err;
    word_t   rd_data;
    logic    rd_valid;

    always #5 CLK = ~CLK;

    debug_csr_unit #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_debug_csr_unit (
        .CLK        (CLK),
        .nRST       (nRST),
        .halt_req   (cur.halt_req),
        .ebreak     (cur.ebreak),
        .step_done  (cur.step_done),
        .core_pc    (cur.core_pc),
        .core_prv   (cur.core_prv),
        .resume_req (cur.resume_req),
        .halted     (halted),
        .resume     (resume),
        .resume_pc  (resume_pc),
        .resume_prv (resume_prv),
        .wr_strobe  (cur.wr_strobe),
        .wr_req     (cur.wr_req),
        .queue_full (queue_full),
        .wr_err     (wr_err),
        .rd_addr    (cur.rd_addr),
        .rd_data    (rd_data),
        .rd_valid   (rd_valid)
    );

    debug_csr_checker u_checker (
        .CLK            (CLK),
        .check_en       (check_en),
        .test_name      (cur.name),
        .vec_idx        (vec_idx),
        .exp_rd_data    (cur.exp_rd_data),
        .exp_rd_valid   (cur.exp_rd_valid),
        .exp_halted     (cur.exp_halted),
        .exp_wr_err     (cur.exp_wr_err),
        .exp_resume     (cur.exp_resume),
        .exp_resume_pc  (cur.exp_resume_pc),
        .exp_resume_prv (cur.exp_resume_prv),
        .exp_queue_full (exp_queue_full),
        .rd_data        (rd_data),
        .rd_valid       (rd_valid),
        .halted         (halted),
        .wr_err         (wr_err),
        .resume         (resume),
        .resume_pc      (resume_pc),
        .resume_prv     (resume_prv),
        .queue_full     (queue_full),
        .error_count    (check_errors)
    );

    // Comment lines start with '#', blank lines are skipped
    task automatic load_vectors();
        int           fd;
        int           n;
        string        line;
        logic [127:0] tag;
        logic [31:0]  c [0:16];
        vector_t      v;
        fd = $fopen("verif/debug_csr_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file");
            file_errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                tag, c[0], c[1], c[2], c[3], c[4], c[5], c[6], c[7], c[8],
                                c[9], c[10], c[11], c[12], c[13], c[14], c[15], c[16]);
                    if (n != 18) begin
                        $display("Malformed vector line: %s", line);
                        file_errors++;
                    end else begin
                        v.name           = tag;
                        v.halt_req       = c[0][0];
                        v.ebreak         = c[1][0];
                        v.step_done      = c[2][0];
                        v.core_pc        = c[3];
                        v.core_prv       = c[4][1:0];
                        v.resume_req     = c[5][0];
                        v.wr_strobe      = c[6][0];
                        v.wr_req.addr    = c[7][11:0];
                        v.wr_req.wdata   = c[8];
                        v.rd_addr        = c[9][11:0];
                        v.exp_rd_data    = c[10];
                        v.exp_rd_valid   = c[11][0];
                        v.exp_halted     = c[12][0];
                        v.exp_wr_err     = c[13][0];
                        v.exp_resume     = c[14][0];
                        v.exp_resume_pc  = c[15];
                        v.exp_resume_prv = c[16][1:0];
                        vecs.push_back(v);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        CLK            = 1'b0;
        nRST           = 1'b0;
        cur            = '0;
        check_en       = 1'b0;
        loaded         = 1'b0;
        vec_idx        = 0;
        file_errors    = 0;
        queue_level    = 0;
        exp_queue_full = 1'b0;
        entry_cycle    = 1'b0;
        load_vectors();
        vec_count = vecs.size();
        if (vec_count == 0) begin
            $display("No vectors were loaded");
            file_errors++;
        end
        loaded = 1'b1;
        repeat (4) @(posedge CLK);
        #1;
        nRST = 1'b1;
        for (int i = 0; i < vec_count; i++) begin
            cur            = vecs[i];
            vec_idx        = i;
            exp_queue_full = (queue_level == QUEUE_DEPTH);
            // Entry strobe falls in the cycle where halted rises and holds the pop back
            entry_cycle = cur.exp_halted && (i == 0 || !vecs[i-1].exp_halted);
            if (queue_level > 0 && !entry_cycle) begin
                queue_level--;
            end
            if (cur.wr_strobe && !exp_queue_full) begin
                queue_level++;
            end
            check_en = 1'b1;
            @(posedge CLK);
            #1;
        end
        check_en     = 1'b0;
        total_errors = file_errors + check_errors;
        $display("Vectors run: %0d, errors: %0d", vec_count, total_errors);
        if (total_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Watchdog sized from the vector count
    initial begin
        wait (loaded);
        #((vec_count + 20) * 10);
        $display("Run timed out before all vectors were applied");
        $display("Finished with errors");
        $finish;
    end

endmodule

/* verif/debug_csr_checker.sv */
module debug_csr_checker (
    input  logic                  CLK,
    input  logic                  check_en,
    input  logic [127:0]          test_name,
    input  int                    vec_idx,
    input  debug_csr_pkg::word_t  exp_rd_data,
    input  logic                  exp_rd_valid,
    input  logic                  exp_halted,
    input  logic                  exp_wr_err,
    input  logic                  exp_resume,
    input  debug_csr_pkg::word_t  exp_resume_pc,
    input  debug_csr_pkg::priv_t  exp_resume_prv,
    input  logic                  exp_queue_full,
    input  debug_csr_pkg::word_t  rd_data,
    input  logic                  rd_valid,
    input  logic                  halted,
    input  logic                  wr_err,
    input  logic                  resume,
    input  debug_csr_pkg::word_t  resume_pc,
    input  debug_csr_pkg::priv_t  resume_prv,
    input  logic                  queue_full,
    output int                    error_count
);
    import debug_csr_pkg::*;

    task automatic compare(input string field, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            error_count++;
            $display("FAILED %0s (vector %0d) %0s: expected %h, actual %h",
                     test_name, vec_idx, field, expected, actual);
        end
    endtask

    initial begin
        error_count = 0;
    end

    // Inputs change 1 unit after the edge, sample 1 unit before the next one
    always @(posedge CLK) begin
        #9;
        if (check_en) begin
            compare("rd_data", exp_rd_data, rd_data);
            compare("rd_valid", word_t'(exp_rd_valid), word_t'(rd_valid));
            compare("halted", word_t'(exp_halted), word_t'(halted));
            compare("wr_err", word_t'(exp_wr_err), word_t'(wr_err));
            compare("resume", word_t'(exp_resume), word_t'(resume));
            compare("resume_pc", exp_resume_pc, resume_pc);
            compare("resume_prv", word_t'(exp_resume_prv), word_t'(resume_prv));
            compare("queue_full", word_t'(exp_queue_full), word_t'(queue_full));
        end
    end

endmodule

/* rtl/debug_csr_unit.sv */
module debug_csr_unit #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                      CLK,
    input  logic                      nRST,
    // Core side
    input  logic                      halt_req,
    input  logic                      ebreak,
    input  logic                      step_done,
    input  debug_csr_pkg::word_t      core_pc,
    input  debug_csr_pkg::priv_t      core_prv,
    input  logic                      resume_req,
    output logic                      halted,
    output logic                      resume,
    output debug_csr_pkg::word_t      resume_pc,
    output debug_csr_pkg::priv_t      resume_prv,
    // Debugger side
    input  logic                      wr_strobe,
    input  debug_csr_pkg::csr_req_t   wr_req,
    output logic                      queue_full,
    output logic                      wr_err,
    input  debug_csr_pkg::csr_addr_t  rd_addr,
    output debug_csr_pkg::word_t      rd_data,
    output logic                      rd_valid
);
    import debug_csr_pkg::*;

    logic       entry_strobe;
    dbg_entry_t entry;
    dcsr_t      dcsr;
    word_t      dpc;
    csr_req_t   head;
    logic       not_empty;
    logic       pop;

    debug_entry_ctrl u_debug_entry_ctrl (
        .CLK          (CLK),
        .nRST         (nRST),
        .halt_req     (halt_req),
        .ebreak       (ebreak),
        .step_done    (step_done),
        .core_pc      (core_pc),
        .core_prv     (core_prv),
        .resume_req   (resume_req),
        .dcsr         (dcsr),
        .dpc          (dpc),
        .entry_strobe (entry_strobe),
        .entry        (entry),
        .halted       (halted),
        .resume       (resume),
        .resume_pc    (resume_pc),
        .resume_prv   (resume_prv)
    );

    csr_req_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_csr_req_queue (
        .CLK       (CLK),
        .nRST      (nRST),
        .push      (wr_strobe),
        .push_req  (wr_req),
        .pop       (pop),
        .head      (head),
        .not_empty (not_empty),
        .full      (queue_full)
    );

    debug_csr_file u_debug_csr_file (
        .CLK          (CLK),
        .nRST         (nRST),
        .halted       (halted),
        .entry_strobe (entry_strobe),
        .entry        (entry),
        .not_empty    (not_empty),
        .head         (head),
        .pop          (pop),
        .wr_err       (wr_err),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .rd_valid     (rd_valid),
        .dcsr         (dcsr),
        .dpc          (dpc)
    );

endmodule

/* rtl/debug_csr_file.sv */
module debug_csr_file (
    input  logic                       CLK,
    input  logic                       nRST,
    input  logic                       halted,
    input  logic                       entry_strobe,
    input  debug_csr_pkg::dbg_entry_t  entry,
    input  logic                       not_empty,
    input  debug_csr_pkg::csr_req_t    head,
    output logic                       pop,
    output logic                       wr_err,
    input  debug_csr_pkg::csr_addr_t   rd_addr,
    output debug_csr_pkg::word_t       rd_data,
    output logic                       rd_valid,
    output debug_csr_pkg::dcsr_t       dcsr,
    output debug_csr_pkg::word_t       dpc
);
    import debug_csr_pkg::*;

    word_t dscratch0, dscratch1;
    dcsr_t nxt_dcsr, wr_dcsr;
    word_t nxt_dpc, nxt_dscratch0, nxt_dscratch1;
    logic  addr_known;
    logic  wr_ok;

    // Entry owns the register file for its cycle
    assign pop = not_empty && !entry_strobe;

    assign addr_known = (head.addr == ADDR_DCSR) || (head.addr == ADDR_DPC) ||
                        (head.addr == ADDR_DSCRATCH0) || (head.addr == ADDR_DSCRATCH1);
    assign wr_ok   = pop && halted && addr_known;
    assign wr_dcsr = dcsr_t'(head.wdata);

    always_comb begin
        nxt_dcsr      = dcsr;
        nxt_dpc       = dpc;
        nxt_dscratch0 = dscratch0;
        nxt_dscratch1 = dscratch1;

        if (entry_strobe) begin
            nxt_dpc       = entry.pc;
            nxt_dcsr.cause = entry.cause;
            nxt_dcsr.prv   = entry.prv;
        end else if (wr_ok) begin
            case (head.addr)
                ADDR_DCSR: begin
                    // Only the writable fields follow wdata
                    nxt_dcsr.ebreakm = wr_dcsr.ebreakm;
                    nxt_dcsr.ebreaks = wr_dcsr.ebreaks;
                    nxt_dcsr.ebreaku = wr_dcsr.ebreaku;
                    nxt_dcsr.step    = wr_dcsr.step;
                    // Privilege 2 is reserved, keep the old level
                    if (wr_dcsr.prv != 2'd2) begin
                        nxt_dcsr.prv = wr_dcsr.prv;
                    end
                end
                ADDR_DPC:       nxt_dpc       = head.wdata;
                ADDR_DSCRATCH0: nxt_dscratch0 = head.wdata;
                ADDR_DSCRATCH1: nxt_dscratch1 = head.wdata;
                default: ;
            endcase
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            dcsr      <= DCSR_RESET;
            dpc       <= '0;
            dscratch0 <= '0;
            dscratch1 <= '0;
            wr_err    <= 1'b0;
        end else begin
            dcsr      <= nxt_dcsr;
            dpc       <= nxt_dpc;
            dscratch0 <= nxt_dscratch0;
            dscratch1 <= nxt_dscratch1;
            // Rejected pop: unknown address or hart running
            wr_err    <= pop && !wr_ok;
        end
    end

    // Debugger read port
    always_comb begin
        rd_valid = 1'b1;
        case (rd_addr)
            ADDR_DCSR:      rd_data = dcsr;
            ADDR_DPC:       rd_data = dpc;
            ADDR_DSCRATCH0: rd_data = dscratch0;
            ADDR_DSCRATCH1: rd_data = dscratch1;
            default: begin
                rd_data  = '0;
                rd_valid = 1'b0;
            end
        endcase
    end

endmodule

/* rtl/csr_req_queue.sv */
module csr_req_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                      CLK,
    input  logic                      nRST,
    input  logic                      push,
    input  debug_csr_pkg::csr_req_t   push_req,
    input  logic                      pop,
    output debug_csr_pkg::csr_req_t   head,
    output logic                      not_empty,
    output logic                      full
);
    import debug_csr_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [PTR_W:0]   count_t;

    csr_req_t mem [QUEUE_DEPTH];
    ptr_t     wr_ptr, rd_ptr;
    count_t   count;
    logic     do_push, do_pop;

    // Overflow and underflow are silently ignored
    assign do_push = push && !full;
    assign do_pop  = pop && not_empty;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + ptr_t'(1);
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + ptr_t'(1);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + count_t'(1);
                2'b01:   count <= count - count_t'(1);
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (do_push) begin
            mem[wr_ptr] <= push_req;
        end
    end

    assign head      = mem[rd_ptr];
    assign not_empty = (count != '0);
    assign full      = (count == count_t'(QUEUE_DEPTH));

endmodule

/* rtl/debug_entry_ctrl.sv */
module debug_entry_ctrl (
    input  logic                       CLK,
    input  logic                       nRST,
    input  logic                       halt_req,
    input  logic                       ebreak,
    input  logic                       step_done,
    input  debug_csr_pkg::word_t       core_pc,
    input  debug_csr_pkg::priv_t       core_prv,
    input  logic                       resume_req,
    input  debug_csr_pkg::dcsr_t       dcsr,
    input  debug_csr_pkg::word_t       dpc,
    output logic                       entry_strobe,
    output debug_csr_pkg::dbg_entry_t  entry,
    output logic                       halted,
    output logic                       resume,
    output debug_csr_pkg::word_t       resume_pc,
    output debug_csr_pkg::priv_t       resume_prv
);
    import debug_csr_pkg::*;

    ctrl_state_t state, nxt_state;
    logic        ebreak_en;
    logic        enter;
    dbg_cause_t  enter_cause;

    // ebreak enable bit for the current privilege level
    always_comb begin
        case (core_prv)
            2'd3:    ebreak_en = dcsr.ebreakm;
            2'd1:    ebreak_en = dcsr.ebreaks;
            2'd0:    ebreak_en = dcsr.ebreaku;
            default: ebreak_en = 1'b0;
        endcase
    end

    // Cause priority: ebreak, then haltreq, then step
    always_comb begin
        enter       = 1'b0;
        enter_cause = CAUSE_HALTREQ;
        if (ebreak && ebreak_en) begin
            enter       = 1'b1;
            enter_cause = CAUSE_EBREAK;
        end else if (halt_req) begin
            enter       = 1'b1;
            enter_cause = CAUSE_HALTREQ;
        end else if (step_done && dcsr.step) begin
            enter       = 1'b1;
            enter_cause = CAUSE_STEP;
        end
    end

    always_comb begin
        nxt_state = state;
        case (state)
            ST_RUNNING: if (enter) nxt_state = ST_HALTED;
            ST_HALTED:  if (resume_req) nxt_state = ST_RUNNING;
            default:    nxt_state = ST_RUNNING;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state        <= ST_RUNNING;
            entry_strobe <= 1'b0;
            resume       <= 1'b0;
        end else begin
            state        <= nxt_state;
            entry_strobe <= (state == ST_RUNNING) && enter;
            resume       <= (state == ST_HALTED) && resume_req;
        end
    end

    // Entry record, only consumed while entry_strobe is high
    always_ff @(posedge CLK) begin
        if (state == ST_RUNNING && enter) begin
            entry <= '{pc: core_pc, cause: enter_cause, prv: core_prv};
        end
    end

    assign halted = (state == ST_HALTED);

    // Return state follows the live CSRs
    assign resume_pc  = dpc;
    assign resume_prv = dcsr.prv;

endmodule

/* rtl/debug_csr_pkg.sv */
package debug_csr_pkg;

    // Widths with a meaning of their own
    typedef logic [31:0] word_t;
    typedef logic [11:0] csr_addr_t;
    typedef logic [1:0]  priv_t;
    typedef logic [2:0]  dbg_cause_t;

    // dcsr cause encodings
    localparam dbg_cause_t CAUSE_EBREAK  = 3'd1;
    localparam dbg_cause_t CAUSE_HALTREQ = 3'd3;
    localparam dbg_cause_t CAUSE_STEP    = 3'd4;

    // Debug CSR addresses
    localparam csr_addr_t ADDR_DCSR      = 12'h7b0;
    localparam csr_addr_t ADDR_DPC       = 12'h7b1;
    localparam csr_addr_t ADDR_DSCRATCH0 = 12'h7b2;
    localparam csr_addr_t ADDR_DSCRATCH1 = 12'h7b3;

    // dcsr layout, unsupported fields kept as zero
    typedef struct packed {
        logic [3:0]  xdebugver;
        logic [11:0] rsvd_27_16;
        logic        ebreakm;
        logic        rsvd_14;
        logic        ebreaks;
        logic        ebreaku;
        logic [2:0]  rsvd_11_9;
        dbg_cause_t  cause;
        logic [2:0]  rsvd_5_3;
        logic        step;
        priv_t       prv;
    } dcsr_t;

    // xdebugver 4, prv M, everything else clear
    localparam dcsr_t DCSR_RESET = dcsr_t'(32'h4000_0003);

    // Debugger write request
    typedef struct packed {
        csr_addr_t addr;
        word_t     wdata;
    } csr_req_t;

    // State captured on debug entry
    typedef struct packed {
        word_t      pc;
        dbg_cause_t cause;
        priv_t      prv;
    } dbg_entry_t;

    typedef enum logic {
        ST_RUNNING,
        ST_HALTED
    } ctrl_state_t;

endpackage
